// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= game_ctrl_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^TB PASSED$$' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
logic/game_pkg.sv
logic/input_sync.sv
logic/lfsr_random.sv
logic/game_control_fsm.sv
logic/hunt_logic.sv
logic/result_link.sv
logic/game_ctrl_top.sv
sim/game_ctrl_tb.sv

// ==== logic/game_control_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_control_fsm import game_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              left_click,
    input  wire [POS_W-1:0]  mouse_xpos,
    input  wire [POS_W-1:0]  mouse_ypos,
    input  wire              enemy_start,
    input  wire              enemy_ended,
    input  wire              out_of_ammo,
    output game_phase_t      phase,
    output logic             play_enable,
    output logic             play_start,
    output logic             start_pressed,
    output logic             game_ended
);

    game_phase_t phase_nxt;
    logic        in_start_box;
    logic        start_hit;

    assign in_start_box = (mouse_xpos >= START_X0) && (mouse_xpos <= START_X1) &&
                          (mouse_ypos >= START_Y0) && (mouse_ypos <= START_Y1);
    assign start_hit    = left_click && in_start_box;

    // Next phase --------------------
    always_comb begin
        phase_nxt = phase;
        case (phase)
            PH_START: begin
                if (start_hit) begin
                    phase_nxt = PH_WAIT_START;
                end
            end
            PH_WAIT_START: begin
                if (enemy_start) begin
                    phase_nxt = PH_PLAY;
                end
            end
            PH_PLAY: begin
                // Counts are still empty while play_start loads them
                if (out_of_ammo && !play_start) begin
                    phase_nxt = PH_WAIT_END;
                end
            end
            PH_WAIT_END: begin
                if (enemy_ended) begin
                    phase_nxt = PH_RESULT;
                end
            end
            PH_RESULT: phase_nxt = PH_RESULT;  // Only reset leaves
            default:   phase_nxt = PH_START;
        endcase
    end

    // Phase register and status flags --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase         <= PH_START;
            play_start    <= 1'b0;
            start_pressed <= 1'b0;
            game_ended    <= 1'b0;
        end else begin
            phase      <= phase_nxt;
            play_start <= (phase == PH_WAIT_START) && (phase_nxt == PH_PLAY);  // Entry pulse
            if ((phase == PH_START) && (phase_nxt == PH_WAIT_START)) begin
                start_pressed <= 1'b1;  // Sticky
            end
            if ((phase == PH_PLAY) && (phase_nxt == PH_WAIT_END)) begin
                game_ended <= 1'b1;     // Sticky
            end
        end
    end

    assign play_enable = (phase == PH_PLAY);

endmodule

`default_nettype wire

// ==== logic/game_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_ctrl_top import game_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire [POS_W-1:0]      mouse_xpos,
    input  wire [POS_W-1:0]      mouse_ypos,
    input  wire                  left_mouse,
    input  wire                  right_mouse,
    input  wire [7:0]            uart_data_in,
    output logic [7:0]           uart_data_out,
    output game_phase_t          phase,
    output logic [POS_W-1:0]     duck_xpos,
    output logic [POS_W-1:0]     duck_ypos,
    output logic [SCORE_W-1:0]   my_score,
    output logic [SCORE_W-1:0]   enemy_score,
    output logic [MAG_W-1:0]     bullets_in_magazine,
    output logic [RESERVE_W-1:0] bullets_left,
    output logic                 show_reload,
    output result_t              winner
);

    logic              left_click;
    logic              right_click;
    logic              enemy_start;
    logic              enemy_ended;
    logic              play_enable;
    logic              play_start;
    logic              start_pressed;
    logic              game_ended;
    logic              out_of_ammo;
    logic              lfsr_enable;
    logic [LFSR_W-1:0] random;

    // Random word keeps running while the player idles on the start screen
    assign lfsr_enable = play_enable || (phase == PH_START);

    // --------------------
    input_sync u_input_sync (
        .clk, .rst_n, .left_mouse, .right_mouse, .uart_data_in,
        .left_click, .right_click, .enemy_start, .enemy_ended, .enemy_score
    );

    lfsr_random u_lfsr_random (
        .clk, .rst_n, .enable(lfsr_enable), .random
    );

    game_control_fsm u_game_control_fsm (
        .clk, .rst_n, .left_click, .mouse_xpos, .mouse_ypos,
        .enemy_start, .enemy_ended, .out_of_ammo,
        .phase, .play_enable, .play_start, .start_pressed, .game_ended
    );

    hunt_logic u_hunt_logic (
        .clk, .rst_n, .play_enable, .play_start, .left_click, .right_click,
        .mouse_xpos, .mouse_ypos, .random,
        .duck_xpos, .duck_ypos, .my_score, .bullets_in_magazine, .bullets_left,
        .show_reload, .out_of_ammo
    );

    result_link u_result_link (
        .clk, .rst_n, .start_pressed, .game_ended, .my_score, .enemy_score,
        .uart_data_out, .winner
    );

endmodule

`default_nettype wire

// ==== logic/game_pkg.sv ====
`default_nettype none

package game_pkg;

    // Game phases --------------------
    typedef enum logic [2:0] {
        PH_START,        // Start screen
        PH_WAIT_START,   // Waiting for enemy to press start
        PH_PLAY,         // Hunting
        PH_WAIT_END,     // Waiting for enemy to run dry
        PH_RESULT        // Final screen
    } game_phase_t;

    typedef enum logic [1:0] {
        RES_TIE,
        RES_WIN,
        RES_LOSS
    } result_t;

    // Widths --------------------
    localparam int POS_W     = 12;  // Screen coordinates
    localparam int SCORE_W   = 7;   // Low 6 bits go over the link
    localparam int MAG_W     = 3;
    localparam int RESERVE_W = 7;
    localparam int LFSR_W    = 10;

    // Ammo --------------------
    localparam logic [MAG_W-1:0]     MAG_SIZE      = 3'd3;
    localparam logic [RESERVE_W-1:0] START_RESERVE = 7'd6;

    // Start button box with inclusive bounds
    localparam logic [POS_W-1:0] START_X0 = 12'd384;
    localparam logic [POS_W-1:0] START_X1 = 12'd639;
    localparam logic [POS_W-1:0] START_Y0 = 12'd300;
    localparam logic [POS_W-1:0] START_Y1 = 12'd363;

    // Duck --------------------
    localparam logic [POS_W-1:0] DUCK_W      = 12'd48;
    localparam logic [POS_W-1:0] DUCK_H      = 12'd40;
    localparam logic [POS_W-1:0] DUCK_X_BASE = 12'd64;
    localparam logic [POS_W-1:0] DUCK_Y_BASE = 12'd64;

    localparam logic [LFSR_W-1:0] LFSR_SEED = 10'h2B5;  // Any nonzero value

endpackage

`default_nettype wire

// ==== logic/hunt_logic.sv ====
`timescale 1ns/1ps
`default_nettype none

module hunt_logic import game_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  play_enable,
    input  wire                  play_start,
    input  wire                  left_click,
    input  wire                  right_click,
    input  wire [POS_W-1:0]      mouse_xpos,
    input  wire [POS_W-1:0]      mouse_ypos,
    input  wire [LFSR_W-1:0]     random,
    output logic [POS_W-1:0]     duck_xpos,
    output logic [POS_W-1:0]     duck_ypos,
    output logic [SCORE_W-1:0]   my_score,
    output logic [MAG_W-1:0]     bullets_in_magazine,
    output logic [RESERVE_W-1:0] bullets_left,
    output logic                 show_reload,
    output logic                 out_of_ammo
);

    logic [POS_W-1:0]     new_xpos;
    logic [POS_W-1:0]     new_ypos;
    logic                 duck_hit;
    logic                 shot;
    logic                 reload;
    logic [MAG_W-1:0]     reload_cnt;

    // Next duck spot from the random word
    assign new_xpos = DUCK_X_BASE + {{(POS_W-9){1'b0}}, random[8:0]};
    assign new_ypos = DUCK_Y_BASE + {{(POS_W-8){1'b0}}, random[7:0]};

    // Hit box includes the lower edges and excludes the upper ones
    assign duck_hit = (mouse_xpos >= duck_xpos) && (mouse_xpos < duck_xpos + DUCK_W) &&
                      (mouse_ypos >= duck_ypos) && (mouse_ypos < duck_ypos + DUCK_H);

    assign shot   = play_enable && left_click && (bullets_in_magazine != '0);
    assign reload = play_enable && right_click && (bullets_in_magazine == '0) &&
                    (bullets_left != '0);

    // Partial magazine when the reserve runs low
    assign reload_cnt = (bullets_left >= RESERVE_W'(MAG_SIZE)) ? MAG_SIZE :
                        bullets_left[MAG_W-1:0];

    // Duck position and score --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            duck_xpos <= DUCK_X_BASE;
            duck_ypos <= DUCK_Y_BASE;
            my_score  <= '0;
        end else if (play_start) begin
            duck_xpos <= new_xpos;
            duck_ypos <= new_ypos;
            my_score  <= '0;
        end else if (shot && duck_hit) begin
            duck_xpos <= new_xpos;  // Jump away after a hit
            duck_ypos <= new_ypos;
            my_score  <= my_score + 1'b1;
        end
    end

    // Magazine and reserve --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bullets_in_magazine <= '0;
            bullets_left        <= '0;
        end else if (play_start) begin
            bullets_in_magazine <= MAG_SIZE;
            bullets_left        <= START_RESERVE;
        end else if (shot) begin
            bullets_in_magazine <= bullets_in_magazine - 1'b1;
        end else if (reload) begin
            bullets_in_magazine <= reload_cnt;
            bullets_left        <= bullets_left - RESERVE_W'(reload_cnt);
        end
    end

    assign show_reload = (bullets_in_magazine == '0) && (bullets_left != '0);
    assign out_of_ammo = (bullets_in_magazine == '0) && (bullets_left == '0);

endmodule

`default_nettype wire

// ==== logic/input_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_sync import game_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                left_mouse,
    input  wire                right_mouse,
    input  wire [7:0]          uart_data_in,
    output logic               left_click,
    output logic               right_click,
    output logic               enemy_start,
    output logic               enemy_ended,
    output logic [SCORE_W-1:0] enemy_score
);

    // Index 0 is the left button, index 1 the right one
    logic [1:0] btn_meta;
    logic [1:0] btn_sync;
    logic [1:0] btn_q;
    logic [1:0] click_q;
    logic [7:0] uart_q;

    // Button synchronizers and edge detect --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_meta <= '0;
            btn_sync <= '0;
            btn_q    <= '0;
            click_q  <= '0;
        end else begin
            btn_meta <= {right_mouse, left_mouse};  // First stage
            btn_sync <= btn_meta;
            btn_q    <= btn_sync;                   // Previous level
            click_q  <= btn_sync & ~btn_q;          // Rising edge only
        end
    end

    assign left_click  = click_q[0];
    assign right_click = click_q[1];

    // Enemy status byte --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uart_q <= 8'h00;
        end else begin
            uart_q <= uart_data_in;
        end
    end

    assign enemy_start = uart_q[7];
    assign enemy_ended = uart_q[6];
    assign enemy_score = {{(SCORE_W-6){1'b0}}, uart_q[5:0]};  // Widen to local score

endmodule

`default_nettype wire

// ==== logic/lfsr_random.sv ====
`timescale 1ns/1ps
`default_nettype none

module lfsr_random import game_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               enable,
    output logic [LFSR_W-1:0] random
);

    logic feedback;

    // Taps 10 and 7 give a maximal length sequence
    assign feedback = random[9] ^ random[6];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            random <= LFSR_SEED;  // All zeros would lock up
        end else if (enable) begin
            random <= {random[LFSR_W-2:0], feedback};
        end
    end

endmodule

`default_nettype wire

// ==== logic/result_link.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_link import game_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               start_pressed,
    input  wire               game_ended,
    input  wire [SCORE_W-1:0] my_score,
    input  wire [SCORE_W-1:0] enemy_score,
    output logic [7:0]        uart_data_out,
    output result_t           winner
);

    result_t winner_nxt;

    // Only the bits that travel on the link are compared
    always_comb begin
        if (my_score[5:0] == enemy_score[5:0]) begin
            winner_nxt = RES_TIE;
        end else if (my_score[5:0] > enemy_score[5:0]) begin
            winner_nxt = RES_WIN;
        end else begin
            winner_nxt = RES_LOSS;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uart_data_out <= 8'h00;
            winner        <= RES_TIE;
        end else begin
            uart_data_out <= {start_pressed, game_ended, my_score[5:0]};  // Status byte out
            winner        <= winner_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== sim/game_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_ctrl_tb import game_pkg::*; ();

    localparam int NUM_ROWS       = 18;
    localparam int NUM_RUNS       = 3;       // Tie, loss, win
    localparam int RELEASE_CYCLES = 4;
    localparam int TIMEOUT_CYCLES = NUM_RUNS * NUM_ROWS * 20;
    localparam logic [1:0] T_START = 2'd0;   // Centre of the start box
    localparam logic [1:0] T_DUCK  = 2'd1;   // Current duck centre
    localparam logic [1:0] T_MISS  = 2'd2;   // Fixed point at 0,0
    localparam logic [1:0] T_RAND  = 2'd3;   // Duck or miss, chosen at random
    localparam int DUCK_SAME   = 0;
    localparam int DUCK_MOVED  = 1;
    localparam int DUCK_PLACED = 2;

    typedef struct packed {
        logic        left;
        logic        right;
        logic [1:0]  target;
        logic [7:0]  uart;
        logic [3:0]  hold;
        game_phase_t phase;                  // Expected phase after the row
    } stim_row_t;

    logic                 clk;
    logic                 rst_n;
    logic [POS_W-1:0]     mouse_xpos;
    logic [POS_W-1:0]     mouse_ypos;
    logic                 left_mouse;
    logic                 right_mouse;
    logic [7:0]           uart_data_in;
    logic [7:0]           uart_data_out;
    game_phase_t          phase;
    logic [POS_W-1:0]     duck_xpos;
    logic [POS_W-1:0]     duck_ypos;
    logic [SCORE_W-1:0]   my_score;
    logic [SCORE_W-1:0]   enemy_score;
    logic [MAG_W-1:0]     bullets_in_magazine;
    logic [RESERVE_W-1:0] bullets_left;
    logic                 show_reload;
    result_t              winner;

    // Reference model state
    game_phase_t      exp_phase;
    int               exp_score;
    int               exp_mag;
    int               exp_res;
    logic             start_flag;
    logic             end_flag;
    logic [7:0]       uart_now;
    logic [POS_W-1:0] prev_x;
    logic [POS_W-1:0] prev_y;
    stim_row_t        stim [NUM_ROWS];
    integer           seed;
    int               error_count;
    int               check_count;
    int               cycle_cnt;

    game_ctrl_top dut_i (
        .clk, .rst_n, .mouse_xpos, .mouse_ypos, .left_mouse, .right_mouse,
        .uart_data_in, .uart_data_out, .phase, .duck_xpos, .duck_ypos, .my_score,
        .enemy_score, .bullets_in_magazine, .bullets_left, .show_reload, .winner
    );

    always #10 clk = ~clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;                                  // Drive just after the edge
        end
    endtask

    task automatic apply_reset();
        rst_n        = 1'b0;
        uart_data_in = 8'h00;
        step_cycles(2);
        rst_n      = 1'b1;
        exp_phase  = PH_START;
        exp_score  = 0;
        exp_mag    = 0;
        exp_res    = 0;
        start_flag = 1'b0;
        end_flag   = 1'b0;
        uart_now   = 8'h00;
        prev_x     = DUCK_X_BASE;
        prev_y     = DUCK_Y_BASE;
    endtask

    // Game rules --------------------
    task automatic update_model(input stim_row_t row, input logic aim_duck,
                                output logic hit, output logic placed);
        int refill;
        hit    = 1'b0;
        placed = 1'b0;
        case (exp_phase)
            PH_START: begin
                if (row.left && row.target == T_START) begin
                    exp_phase  = PH_WAIT_START;
                    start_flag = 1'b1;
                end
            end
            PH_WAIT_START: begin
                if (uart_now[7]) begin
                    exp_phase = PH_PLAY;
                    exp_mag   = 3;
                    exp_res   = 6;
                    exp_score = 0;
                    placed    = 1'b1;
                end
            end
            PH_PLAY: begin
                if (row.left && exp_mag > 0) begin
                    exp_mag--;
                    hit = aim_duck;
                    if (hit) exp_score++;
                end else if (row.right && exp_mag == 0 && exp_res > 0) begin
                    refill  = (exp_res < 3) ? exp_res : 3;
                    exp_mag = refill;
                    exp_res = exp_res - refill;
                end
                if (exp_mag == 0 && exp_res == 0) begin
                    exp_phase = PH_WAIT_END;
                    end_flag  = 1'b1;
                end
            end
            PH_WAIT_END: begin
                if (uart_now[6]) exp_phase = PH_RESULT;
            end
            default: ;
        endcase
    endtask

    task automatic check_outputs(input int duck_mode);
        logic [5:0] enemy_bits;
        logic [5:0] score_bits;
        result_t    exp_winner;
        logic       in_range;
        enemy_bits = uart_now[5:0];
        score_bits = 6'(exp_score);
        if (score_bits == enemy_bits) exp_winner = RES_TIE;
        else if (score_bits > enemy_bits) exp_winner = RES_WIN;
        else exp_winner = RES_LOSS;
        check_value(32'(phase), 32'(exp_phase), "phase");
        check_value(32'(bullets_in_magazine), 32'(exp_mag), "bullets_in_magazine");
        check_value(32'(bullets_left), 32'(exp_res), "bullets_left");
        check_value(32'(my_score), 32'(exp_score), "my_score");
        check_value(32'(show_reload), 32'(exp_mag == 0 && exp_res != 0), "show_reload");
        check_value(32'(uart_data_out), 32'({start_flag, end_flag, score_bits}), "uart_data_out");
        check_value(32'(enemy_score), 32'(enemy_bits), "enemy_score");
        check_value(32'(winner), 32'(exp_winner), "winner");
        if (duck_mode == DUCK_SAME) begin
            check_value(32'(duck_xpos), 32'(prev_x), "duck_xpos unchanged");
            check_value(32'(duck_ypos), 32'(prev_y), "duck_ypos unchanged");
        end else begin
            if (duck_mode == DUCK_MOVED) begin
                check_value(32'(duck_xpos != prev_x || duck_ypos != prev_y), 32'd1,
                            "duck moved after a hit");
            end
            in_range = duck_xpos >= DUCK_X_BASE && duck_xpos <= DUCK_X_BASE + 12'd511 &&
                       duck_ypos >= DUCK_Y_BASE && duck_ypos <= DUCK_Y_BASE + 12'd255;
            check_value(32'(in_range), 32'd1, "duck inside its placement range");
        end
    endtask

    task automatic run_row(input stim_row_t row, input int run);
        logic [31:0] pick;
        logic        aim_duck;
        logic        hit;
        logic        placed;
        int          enemy_val;
        aim_duck = (row.target == T_DUCK);
        if (row.target == T_RAND) begin
            pick     = $random(seed);
            aim_duck = pick[0];
        end
        if (aim_duck) begin
            mouse_xpos = duck_xpos + (DUCK_W >> 1);
            mouse_ypos = duck_ypos + (DUCK_H >> 1);
        end else if (row.target == T_START) begin
            mouse_xpos = (START_X0 + START_X1) >> 1;
            mouse_ypos = (START_Y0 + START_Y1) >> 1;
        end else begin
            mouse_xpos = '0;
            mouse_ypos = '0;
        end
        uart_now = row.uart;
        if (row.uart[6]) begin
            // Enemy score equals, beats, or trails ours depending on the run
            enemy_val     = exp_score + ((run == 1) ? 1 : 0) - ((run == 2) ? 1 : 0);
            uart_now[5:0] = 6'(enemy_val);
        end
        uart_data_in = uart_now;
        prev_x       = duck_xpos;
        prev_y       = duck_ypos;
        left_mouse   = row.left;
        right_mouse  = row.right;
        step_cycles(int'(row.hold));
        left_mouse  = 1'b0;
        right_mouse = 1'b0;
        step_cycles(RELEASE_CYCLES);
        update_model(row, aim_duck, hit, placed);
        check_value(32'(phase), 32'(row.phase), "phase against table");
        if (placed) check_outputs(DUCK_PLACED);
        else if (hit) check_outputs(DUCK_MOVED);
        else check_outputs(DUCK_SAME);
    endtask

    // Stimulus table --------------------
    task automatic fill_table();
        // left, right, target, uart, hold, phase after the row
        stim[0]  = {1'b0, 1'b0, T_MISS,  8'h00, 4'd4, PH_START};
        stim[1]  = {1'b1, 1'b0, T_MISS,  8'h00, 4'd4, PH_START};       // Outside start box
        stim[2]  = {1'b1, 1'b0, T_START, 8'h00, 4'd4, PH_WAIT_START};
        stim[3]  = {1'b0, 1'b0, T_MISS,  8'h80, 4'd4, PH_PLAY};        // Enemy started
        stim[4]  = {1'b0, 1'b1, T_DUCK,  8'h80, 4'd4, PH_PLAY};        // Reload with rounds left
        stim[5]  = {1'b1, 1'b0, T_DUCK,  8'h80, 4'd4, PH_PLAY};
        stim[6]  = {1'b1, 1'b0, T_MISS,  8'h80, 4'd4, PH_PLAY};
        stim[7]  = {1'b1, 1'b0, T_RAND,  8'h80, 4'd4, PH_PLAY};
        stim[8]  = {1'b1, 1'b0, T_DUCK,  8'h80, 4'd4, PH_PLAY};        // Empty magazine
        stim[9]  = {1'b0, 1'b1, T_MISS,  8'h80, 4'd4, PH_PLAY};
        stim[10] = {1'b1, 1'b0, T_RAND,  8'h80, 4'd4, PH_PLAY};
        stim[11] = {1'b1, 1'b0, T_RAND,  8'h80, 4'd4, PH_PLAY};
        stim[12] = {1'b1, 1'b0, T_RAND,  8'h80, 4'd4, PH_PLAY};
        stim[13] = {1'b0, 1'b1, T_MISS,  8'h80, 4'd4, PH_PLAY};        // Last reserve
        stim[14] = {1'b1, 1'b0, T_RAND,  8'h80, 4'd4, PH_PLAY};
        stim[15] = {1'b1, 1'b0, T_RAND,  8'h80, 4'd4, PH_PLAY};
        stim[16] = {1'b1, 1'b0, T_DUCK,  8'h80, 4'd4, PH_WAIT_END};
        stim[17] = {1'b0, 1'b0, T_MISS,  8'hC0, 4'd4, PH_RESULT};      // Enemy ended
    endtask

    // Watchdog --------------------
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        mouse_xpos   = '0;
        mouse_ypos   = '0;
        left_mouse   = 1'b0;
        right_mouse  = 1'b0;
        uart_data_in = 8'h00;
        seed         = 32'h7ad8_0ed3;
        error_count  = 0;
        check_count  = 0;
        fill_table();
        for (int run = 0; run < NUM_RUNS; run++) begin
            apply_reset();
            check_outputs(DUCK_SAME);            // State right after reset
            for (int i = 0; i < NUM_ROWS; i++) begin
                run_row(stim[i], run);
            end
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
